//--- rtl/ppu_pkg.sv
package ppu_pkg;

  // ======================================================================
  // Width types
  // ======================================================================

  // CPU bus
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // Offset inside the 8 KiB VRAM window
  typedef logic [12:0] vram_addr_t;

  // Background index before BGP, shade after it
  typedef logic [1:0]  color_idx_t;

  // Dot in line, line number, screen column
  typedef logic [8:0]  dot_t;
  typedef logic [7:0]  line_t;
  typedef logic [7:0]  xpos_t;

  // STAT mode encoding as seen by the CPU
  typedef enum logic [1:0] {
    MODE_HBLANK   = 2'd0,
    MODE_VBLANK   = 2'd1,
    MODE_OAM_SCAN = 2'd2,
    MODE_TRANSFER = 2'd3
  } ppu_mode_t;

  // Background fetcher steps, one VRAM byte per step
  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_TILE,
    FETCH_LO,
    FETCH_HI,
    FETCH_PUSH
  } fetch_state_t;

  // ======================================================================
  // Screen and timing
  // ======================================================================
  localparam dot_t  DOTS_PER_LINE   = 9'd456;
  localparam line_t LINES_PER_FRAME = 8'd154;
  localparam xpos_t SCREEN_W        = 8'd160;
  localparam line_t SCREEN_H        = 8'd144;
  localparam dot_t  MODE2_LEN       = 9'd80;
  localparam dot_t  MODE3_LEN       = 9'd172;

  // ======================================================================
  // Address map
  // ======================================================================
  localparam addr_t VRAM_START = 16'h8000;
  localparam addr_t VRAM_END   = 16'h9FFF;
  localparam addr_t LCDC       = 16'hFF40;
  localparam addr_t STAT       = 16'hFF41;
  localparam addr_t SCY        = 16'hFF42;
  localparam addr_t SCX        = 16'hFF43;
  localparam addr_t LY         = 16'hFF44;
  localparam addr_t LYC        = 16'hFF45;
  localparam addr_t BGP        = 16'hFF47;

  // Pixel queue slots, two tiles worth
  localparam int FIFO_DEPTH = 16;

endpackage

//--- rtl/pixel_if.sv
`timescale 1ns/1ps

// Pixel stream from the queue to the palette stage
interface pixel_if import ppu_pkg::*; ();

  logic       valid;
  logic       ready;
  color_idx_t color;
  // Flush of queue and x counter, driven from line timing
  logic       line_start;

  modport producer (
    output valid, color,
    input  ready, line_start
  );

  modport consumer (
    input  valid, color, line_start,
    output ready
  );

endinterface

//--- rtl/ppu_timing.sv
`timescale 1ns/1ps

module ppu_timing import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      lcd_on,
  input  line_t     lyc,
  input  logic [3:0] stat_en,
  output dot_t      dot,
  output line_t     ly,
  output ppu_mode_t mode,
  output logic      lyc_match,
  output logic      line_start,
  output logic      vblank_req,
  output logic      stat_req
);

  line_t     ly_prev;
  ppu_mode_t mode_prev;

  // ======================================================================
  // Dot and line counters
  // ======================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= '0;
      ly  <= '0;
    end else if (!lcd_on) begin
      // Held at the top left while the LCD is off
      dot <= '0;
      ly  <= '0;
    end else if (dot == DOTS_PER_LINE - 1) begin
      dot <= '0;
      if (ly == LINES_PER_FRAME - 1) begin
        ly <= '0;
      end else begin
        ly <= ly + 8'd1;
      end
    end else begin
      dot <= dot + 9'd1;
    end
  end

  // Mode from position in frame
  always_comb begin
    if (ly >= SCREEN_H) begin
      mode = MODE_VBLANK;
    end else if (dot < MODE2_LEN) begin
      mode = MODE_OAM_SCAN;
    end else if (dot < MODE2_LEN + MODE3_LEN) begin
      mode = MODE_TRANSFER;
    end else begin
      mode = MODE_HBLANK;
    end
  end

  assign lyc_match = (ly == lyc);

  // First dot of each visible line, well before mode 3
  assign line_start = (dot == '0) && (ly < SCREEN_H);

  // ======================================================================
  // Interrupt pulses
  // ======================================================================
  // Edges found against last cycle's LY and mode
  // Gated by lcd_on so the jump back to line 0 on power-down is silent
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev    <= '0;
      mode_prev  <= MODE_HBLANK;
      vblank_req <= 1'b0;
      stat_req   <= 1'b0;
    end else begin
      ly_prev    <= ly;
      mode_prev  <= mode;
      vblank_req <= lcd_on && (ly != ly_prev) && (ly == SCREEN_H);
      stat_req   <= 1'b0;
      if (lcd_on) begin
        if (stat_en[3] && (ly != ly_prev) && (ly == lyc)) begin
          stat_req <= 1'b1;
        end else if (mode != mode_prev) begin
          // Bits 5, 4, 3 of STAT select modes 2, 1, 0
          stat_req <= (stat_en[2] && mode == MODE_OAM_SCAN)
                   || (stat_en[1] && mode == MODE_VBLANK)
                   || (stat_en[0] && mode == MODE_HBLANK);
        end
      end
    end
  end

  // Counter ranges
  a_dot_range: assert property (@(posedge clk) disable iff (reset) dot < DOTS_PER_LINE);
  a_ly_range: assert property (@(posedge clk) disable iff (reset) ly < LINES_PER_FRAME);

endmodule

//--- rtl/ppu_regs.sv
`timescale 1ns/1ps

module ppu_regs import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  addr_t      addr,
  input  byte_t      wdata,
  input  logic       write_en,
  input  logic       read_en,
  output byte_t      rdata,
  input  ppu_mode_t  mode,
  input  line_t      ly,
  input  logic       lyc_match,
  output byte_t      lcdc,
  output byte_t      scx,
  output byte_t      scy,
  output byte_t      bgp,
  output byte_t      lyc,
  output logic [3:0] stat_en,
  input  vram_addr_t vram_addr,
  output byte_t      vram_rdata
);

  // 8 KiB of tile data and tile maps
  byte_t vram [0:VRAM_END - VRAM_START];

  logic       vram_sel;
  logic       vram_busy;
  vram_addr_t cpu_off;

  // ======================================================================
  // Address decode
  // ======================================================================
  assign vram_sel  = (addr >= VRAM_START) && (addr <= VRAM_END);
  assign cpu_off   = vram_addr_t'(addr - VRAM_START);
  // CPU locked out while the fetcher owns VRAM
  assign vram_busy = (mode == MODE_TRANSFER);

  // ======================================================================
  // Writes
  // ======================================================================
  always_ff @(posedge clk) begin
    if (write_en && vram_sel && !vram_busy) begin
      vram[cpu_off] <= wdata;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc    <= '0;
      scx     <= '0;
      scy     <= '0;
      bgp     <= '0;
      lyc     <= '0;
      stat_en <= '0;
    end else if (write_en) begin
      case (addr)
        LCDC: lcdc <= wdata;
        // Enables only, match flag and mode are read-only
        STAT: stat_en <= wdata[6:3];
        SCY: scy <= wdata;
        SCX: scx <= wdata;
        // LY belongs to the line counter
        LY: ;
        LYC: lyc <= wdata;
        BGP: bgp <= wdata;
        default: ;
      endcase
    end
  end

  // ======================================================================
  // Reads
  // ======================================================================
  // Same-cycle read data, open bus reads FFh
  always_comb begin
    rdata = 8'hFF;
    if (read_en) begin
      if (vram_sel) begin
        rdata = vram_busy ? 8'hFF : vram[cpu_off];
      end else begin
        case (addr)
          LCDC: rdata = lcdc;
          STAT: rdata = {1'b1, stat_en, lyc_match, mode};
          SCY: rdata = scy;
          SCX: rdata = scx;
          LY: rdata = ly;
          LYC: rdata = lyc;
          BGP: rdata = bgp;
          default: rdata = 8'hFF;
        endcase
      end
    end
  end

  // Fetcher side, never blocked
  assign vram_rdata = vram[vram_addr];

  // One CPU access per cycle
  a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(write_en && read_en));

endmodule

//--- rtl/bg_fetcher.sv
`timescale 1ns/1ps

module bg_fetcher import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  ppu_mode_t   mode,
  input  line_t       ly,
  input  byte_t       lcdc,
  input  byte_t       scx,
  input  byte_t       scy,
  output vram_addr_t  vram_addr,
  input  byte_t       vram_rdata,
  output logic        push,
  output logic [15:0] push_data,
  input  logic        fifo_space
);

  fetch_state_t state;
  logic [4:0]   col;
  logic [4:0]   map_col;
  line_t        bg_row;
  byte_t        tile_num;
  byte_t        data_lo;
  byte_t        data_hi;
  vram_addr_t   map_addr;
  vram_addr_t   data_addr;

  // ======================================================================
  // VRAM addressing
  // ======================================================================
  // Background row wraps at 256
  assign bg_row = ly + scy;

  // First tile of the line is read straight out of idle
  assign map_col = (state == FETCH_IDLE) ? scx[7:3] : col;

  // Map at 1800h or 1C00h, 32 tiles per row
  assign map_addr = {2'b11, lcdc[3], bg_row[7:3], map_col};

  // LCDC bit 4 clear gives signed tile numbers around 1000h
  assign data_addr = {~(lcdc[4] | tile_num[7]), tile_num, bg_row[2:0],
                      state == FETCH_HI};

  assign vram_addr = (state == FETCH_LO || state == FETCH_HI) ? data_addr : map_addr;

  // ======================================================================
  // Fetch FSM
  // ======================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= FETCH_IDLE;
      col   <= '0;
    end else if (mode != MODE_TRANSFER) begin
      state <= FETCH_IDLE;
    end else begin
      case (state)
        FETCH_IDLE: begin
          col   <= scx[7:3];
          state <= FETCH_LO;
        end
        FETCH_TILE: state <= FETCH_LO;
        FETCH_LO: state <= FETCH_HI;
        FETCH_HI: state <= FETCH_PUSH;
        // Stall here until eight slots are free
        FETCH_PUSH: begin
          if (fifo_space) begin
            col   <= col + 5'd1;
            state <= FETCH_TILE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Fetched bytes
  always_ff @(posedge clk) begin
    case (state)
      FETCH_IDLE, FETCH_TILE: tile_num <= vram_rdata;
      FETCH_LO: data_lo <= vram_rdata;
      FETCH_HI: data_hi <= vram_rdata;
      default: ;
    endcase
  end

  assign push = (state == FETCH_PUSH) && (mode == MODE_TRANSFER) && fifo_space;

  // Slot 0 is the leftmost pixel, taken from bit 7
  // Background disabled gives index 0
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_data[2*i +: 2] = lcdc[0] ? {data_hi[7-i], data_lo[7-i]} : 2'b00;
    end
  end

endmodule

//--- rtl/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic [15:0] push_data,
  output logic        fifo_space,
  input  byte_t       scx,
  pixel_if.producer   pix
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  color_idx_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic [2:0]       drop_cnt;
  logic             dropping;
  logic             pop;

  // Fine scroll pixels leave without showing on the stream
  assign dropping   = (count != '0) && (drop_cnt != '0);
  assign pix.valid  = (count != '0) && (drop_cnt == '0);
  assign pix.color  = mem[rd_ptr];
  assign pop        = dropping || (pix.valid && pix.ready);
  // Room for a whole tile row
  assign fifo_space = (count <= FIFO_DEPTH - 8);

  // Eight slots per push
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + PTR_W'(i)] <= push_data[2*i +: 2];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      drop_cnt <= '0;
    end else if (pix.line_start) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      drop_cnt <= scx[2:0];
    end else begin
      if (push) wr_ptr <= wr_ptr + PTR_W'(8);
      if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
      if (dropping) drop_cnt <= drop_cnt - 3'd1;
      count <= count + (push ? (PTR_W+1)'(8) : '0) - (PTR_W+1)'(pop);
    end
  end

  // Fetcher honours the space flag
  a_push_space: assert property (@(posedge clk) disable iff (reset) push |-> fifo_space);
  a_no_overflow: assert property (@(posedge clk) disable iff (reset) count <= FIFO_DEPTH);

endmodule

//--- rtl/pixel_output.sv
`timescale 1ns/1ps

module pixel_output import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ppu_mode_t  mode,
  input  line_t      ly,
  input  byte_t      bgp,
  pixel_if.consumer  pix,
  output logic       pixel_valid,
  output xpos_t      pixel_x,
  output line_t      pixel_y,
  output color_idx_t pixel_shade
);

  xpos_t x;
  logic  fire;

  // Accept only during transfer and until the line is full
  assign pix.ready = (mode == MODE_TRANSFER) && (x < SCREEN_W);
  assign fire      = pix.valid && pix.ready;

  // Column counter
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x <= '0;
    end else if (pix.line_start) begin
      x <= '0;
    end else if (fire) begin
      x <= x + 8'd1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= fire;
    end
  end

  // Screen position and shade, two BGP bits per index
  always_ff @(posedge clk) begin
    if (fire) begin
      pixel_x     <= x;
      pixel_y     <= ly;
      pixel_shade <= bgp[2*pix.color +: 2];
    end
  end

endmodule

//--- rtl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  // CPU bus
  input  addr_t      addr,
  input  byte_t      wdata,
  input  logic       write_en,
  input  logic       read_en,
  output byte_t      rdata,
  // Interrupt requests
  output logic       vblank_req,
  output logic       stat_req,
  // Screen
  output logic       pixel_valid,
  output xpos_t      pixel_x,
  output line_t      pixel_y,
  output color_idx_t pixel_shade
);

  byte_t       lcdc, scx, scy, bgp, lyc;
  logic [3:0]  stat_en;
  line_t       ly;
  ppu_mode_t   mode;
  logic        lyc_match;
  logic        line_start;
  vram_addr_t  vram_addr;
  byte_t       vram_rdata;
  logic        push;
  logic [15:0] push_data;
  logic        fifo_space;

  pixel_if pix ();

  // Line flush shared by queue and x counter
  assign pix.line_start = line_start;

  // ======================================================================
  // Blocks
  // ======================================================================
  ppu_timing u_timing (
    .clk, .reset, .lcd_on(lcdc[7]), .lyc, .stat_en, .dot(), .ly, .mode,
    .lyc_match, .line_start, .vblank_req, .stat_req
  );

  ppu_regs u_regs (
    .clk, .reset, .addr, .wdata, .write_en, .read_en, .rdata, .mode, .ly,
    .lyc_match, .lcdc, .scx, .scy, .bgp, .lyc, .stat_en, .vram_addr, .vram_rdata
  );

  bg_fetcher u_fetcher (
    .clk, .reset, .mode, .ly, .lcdc, .scx, .scy, .vram_addr, .vram_rdata,
    .push, .push_data, .fifo_space
  );

  pixel_fifo u_fifo (
    .clk, .reset, .push, .push_data, .fifo_space, .scx, .pix(pix.producer)
  );

  pixel_output u_output (
    .clk, .reset, .mode, .ly, .bgp, .pix(pix.consumer), .pixel_valid,
    .pixel_x, .pixel_y, .pixel_shade
  );

endmodule

//--- tests/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb import ppu_pkg::*; ();

  // Four frames of run time plus the VRAM sweep, with margin
  localparam int TIMEOUT_CYCLES = 300000;
  localparam int FRAME_CYCLES   = int'(DOTS_PER_LINE) * int'(LINES_PER_FRAME);

  logic       clk;
  logic       reset;
  addr_t      addr;
  byte_t      wdata;
  logic       write_en;
  logic       read_en;
  byte_t      rdata;
  logic       vblank_req;
  logic       stat_req;
  logic       pixel_valid;
  xpos_t      pixel_x;
  line_t      pixel_y;
  color_idx_t pixel_shade;

  integer      seed;
  logic [31:0] rnd;
  int          errors;
  int          errors_mark;
  int          tests_run;
  int          tests_failed;
  int          cycles;

  // Reference copies of VRAM and the LCD registers
  byte_t vram_model [0:8191];
  byte_t lcdc_m, scx_m, scy_m, bgp_m, lyc_m;
  int    line_cnt [0:143];

  ppu_top UUT (
    .clk, .reset, .addr, .wdata, .write_en, .read_en, .rdata, .vblank_req,
    .stat_req, .pixel_valid, .pixel_x, .pixel_y, .pixel_shade
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ======================================================================
  // Reference picture
  // ======================================================================
  // Background shade at screen x, y from map, tile data, scroll and BGP
  function automatic color_idx_t model_shade(input xpos_t x, input line_t y);
    line_t      row;
    byte_t      col;
    int         map_off;
    int         data_off;
    int         bit_pos;
    byte_t      tile;
    byte_t      lo;
    byte_t      hi;
    color_idx_t idx;
    row     = y + scy_m;
    col     = x + scx_m;
    map_off = (lcdc_m[3] ? 'h1C00 : 'h1800) + int'(row[7:3]) * 32 + int'(col[7:3]);
    tile    = vram_model[map_off];
    // Unsigned from 8000h, or signed around 9000h
    if (lcdc_m[4]) begin
      data_off = int'(tile) * 16;
    end else begin
      data_off = 'h1000 + int'($signed(tile)) * 16;
    end
    data_off = data_off + int'(row[2:0]) * 2;
    lo       = vram_model[data_off];
    hi       = vram_model[data_off + 1];
    bit_pos  = 7 - int'(col[2:0]);
    idx      = lcdc_m[0] ? {hi[bit_pos], lo[bit_pos]} : 2'd0;
    return bgp_m[2*idx +: 2];
  endfunction

  // ======================================================================
  // CPU bus
  // ======================================================================
  // Write lands on the next rising edge
  task automatic write_byte(input addr_t a, input byte_t d);
    @(posedge clk);
    #2;
    addr     = a;
    wdata    = d;
    write_en = 1'b1;
    read_en  = 1'b0;
    @(negedge clk);
  endtask

  // Same-cycle read, sampled mid-cycle
  task automatic read_byte(input addr_t a, output byte_t d);
    @(posedge clk);
    #2;
    addr     = a;
    write_en = 1'b0;
    read_en  = 1'b1;
    @(negedge clk);
    d = rdata;
  endtask

  task automatic idle_cycles(input int n);
    @(posedge clk);
    #2;
    write_en = 1'b0;
    read_en  = 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    assert (got == exp) else begin
      $display("Error %0t: %s read %02h, expected %02h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error %0t: %s was %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_mark) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_mark);
      tests_failed++;
    end
    errors_mark = errors;
  endtask

  // ======================================================================
  // Tests
  // ======================================================================
  task automatic registers_readback();
    byte_t d;
    byte_t w;
    addr_t a;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      // LCD stays off here
      lcdc_m = rnd[7:0] & 8'h7F;
      scx_m  = rnd[15:8];
      scy_m  = rnd[23:16];
      bgp_m  = rnd[31:24];
      rnd    = $random(seed);
      lyc_m  = rnd[7:0];
      write_byte(LCDC, lcdc_m);
      write_byte(SCX, scx_m);
      write_byte(SCY, scy_m);
      write_byte(LYC, lyc_m);
      write_byte(BGP, bgp_m);
      read_byte(LCDC, d);
      check_byte("LCDC", d, lcdc_m);
      read_byte(SCX, d);
      check_byte("SCX", d, scx_m);
      read_byte(SCY, d);
      check_byte("SCY", d, scy_m);
      read_byte(LYC, d);
      check_byte("LYC", d, lyc_m);
      read_byte(BGP, d);
      check_byte("BGP", d, bgp_m);
      // Enables plus fixed bit 7, match flag against LY of 0
      w = rnd[15:8];
      write_byte(STAT, w);
      read_byte(STAT, d);
      check_byte("STAT enables", d & 8'hF8, {1'b1, w[6:3], 3'b000});
      check_byte("STAT match", {7'd0, d[2]}, {7'd0, lyc_m == 8'd0});
      write_byte(LY, rnd[23:16]);
      read_byte(LY, d);
      check_byte("LY", d, 8'h00);
      // FF4C to FF6B holds nothing
      a = 16'hFF4C + {11'd0, rnd[28:24]};
      read_byte(a, d);
      check_byte("unmapped", d, 8'hFF);
    end
    report_test("registers");
  endtask

  task automatic vram_access();
    byte_t d;
    int    off;
    for (int i = 0; i < 8192; i++) begin
      rnd = $random(seed);
      vram_model[i] = rnd[7:0];
      write_byte(VRAM_START + addr_t'(i), rnd[7:0]);
    end
    for (int i = 0; i < 8192; i++) begin
      read_byte(VRAM_START + addr_t'(i), d);
      check_byte("VRAM", d, vram_model[i]);
    end
    // Lockout while the fetcher owns VRAM
    for (int k = 0; k < 4; k++) begin
      rnd = $random(seed);
      off = int'(rnd[12:0]);
      write_byte(LCDC, 8'h80);
      d = 8'h00;
      while (d[1:0] != 2'd3) begin
        read_byte(STAT, d);
      end
      read_byte(VRAM_START + addr_t'(off), d);
      check_byte("VRAM in mode 3", d, 8'hFF);
      write_byte(VRAM_START + addr_t'(off), ~vram_model[off]);
      write_byte(LCDC, 8'h00);
      // Counters fall back to line 0 a cycle later
      idle_cycles(2);
      read_byte(VRAM_START + addr_t'(off), d);
      check_byte("VRAM after blocked write", d, vram_model[off]);
    end
    lcdc_m = 8'h00;
    report_test("VRAM access");
  endtask

  task automatic picture_frame();
    color_idx_t exp;
    rnd    = $random(seed);
    scx_m  = rnd[7:0];
    scy_m  = rnd[15:8];
    bgp_m  = rnd[23:16];
    // Random BG enable, map select, tile data select
    lcdc_m = 8'h80 | (rnd[31:24] & 8'h19);
    write_byte(SCX, scx_m);
    write_byte(SCY, scy_m);
    write_byte(BGP, bgp_m);
    for (int y = 0; y < 144; y++) begin
      line_cnt[y] = 0;
    end
    write_byte(LCDC, lcdc_m);
    idle_cycles(0);
    // Visible lines end at the VBlank pulse
    do begin
      @(negedge clk);
      if (pixel_valid) begin
        assert (pixel_y < SCREEN_H) else begin
          $display("Error %0t: pixel on line %0d below the screen", $time, pixel_y);
          errors++;
        end
        if (pixel_y < SCREEN_H) begin
          exp = model_shade(pixel_x, pixel_y);
          assert (int'(pixel_x) == line_cnt[pixel_y]) else begin
            $display("Error %0t: pixel x %0d out of order on line %0d", $time,
                     pixel_x, pixel_y);
            errors++;
          end
          assert (pixel_shade == exp) else begin
            $display("Error %0t: pixel (%0d,%0d) shade %0d, expected %0d", $time,
                     pixel_x, pixel_y, pixel_shade, exp);
            errors++;
          end
          line_cnt[pixel_y]++;
        end
      end
    end while (!vblank_req);
    for (int y = 0; y < 144; y++) begin
      expect_count($sformatf("pixel count of line %0d", y), line_cnt[y], 160);
    end
    report_test("picture");
  endtask

  // VBlank and LYC pulses share one two-frame window
  task automatic interrupt_pulses();
    byte_t d;
    int    vblanks;
    int    stats;
    int    vblank_bad;
    int    stat_bad;
    write_byte(LCDC, lcdc_m & 8'h7F);
    idle_cycles(2);
    rnd   = $random(seed);
    lyc_m = 8'd1 + 8'(rnd % 153);
    // LYC source only
    write_byte(STAT, 8'h40);
    write_byte(LYC, lyc_m);
    write_byte(LCDC, lcdc_m);
    // LY stays on the bus from here on
    read_byte(LY, d);
    vblanks    = 0;
    stats      = 0;
    vblank_bad = 0;
    stat_bad   = 0;
    repeat (2 * FRAME_CYCLES) begin
      @(negedge clk);
      if (vblank_req) begin
        vblanks++;
        assert (rdata == SCREEN_H) else begin
          $display("Error %0t: LY read %0d at VBlank pulse, expected 144", $time, rdata);
          vblank_bad++;
        end
      end
      if (stat_req) begin
        stats++;
        assert (rdata == lyc_m) else begin
          $display("Error %0t: LY read %0d at STAT pulse, expected %0d", $time,
                   rdata, lyc_m);
          stat_bad++;
        end
      end
    end
    errors += vblank_bad;
    expect_count("VBlank pulses in two frames", vblanks, 2);
    report_test("VBlank");
    errors += stat_bad;
    expect_count("STAT pulses in two frames", stats, 2);
    report_test("STAT interrupt");
  endtask

  task automatic lcd_off_idle();
    byte_t d;
    int    events;
    rnd    = $random(seed);
    lcdc_m = rnd[7:0] & 8'h7F;
    write_byte(LCDC, lcdc_m);
    idle_cycles(2);
    read_byte(LY, d);
    check_byte("LY with LCD off", d, 8'h00);
    events = 0;
    repeat (1000) begin
      @(negedge clk);
      if (pixel_valid || vblank_req || stat_req) begin
        events++;
      end
    end
    expect_count("pixels and pulses with LCD off", events, 0);
    report_test("LCD off");
  endtask

  // ======================================================================
  // Sequence
  // ======================================================================
  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    addr         = '0;
    wdata        = '0;
    write_en     = 1'b0;
    read_en      = 1'b0;
    seed         = 32'h3428c7de;
    errors       = 0;
    errors_mark  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;

    registers_readback();
    vram_access();
    picture_frame();
    interrupt_pulses();
    lcd_off_idle();

    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
rtl/ppu_pkg.sv
rtl/pixel_if.sv
rtl/ppu_timing.sv
rtl/ppu_regs.sv
rtl/bg_fetcher.sv
rtl/pixel_fifo.sv
rtl/pixel_output.sv
rtl/ppu_top.sv
tests/ppu_tb.sv

//--- Makefile
TOP := ppu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o ppu_sim
	@out="$$(./obj_dir/ppu_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
